/* hw/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // Datapath widths
    localparam int XLEN           = 32;
    localparam int SHAMT_W        = 5;
    localparam int BYTES_PER_WORD = 4;
    localparam int REG_ADDR_W     = 5;

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [REG_ADDR_W-1:0]     reg_addr_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // Operations as decoded by the previous stage
    typedef enum logic [5:0] {
        // Integer ALU
        NOP, ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA, SLT, SLTU, LUI, AUIPC,
        // Control transfer
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        // Memory
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        // System
        ECALL, EBREAK
    } exec_op_e;

    // Standard mcause values for machine mode
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR         = 4'd2,
        BREAKPOINT            = 4'd3,
        LOAD_ADDR_MISALIGNED  = 4'd4,
        STORE_ADDR_MISALIGNED = 4'd6,
        ECALL_MMODE           = 4'd11,
        EXC_NONE              = 4'd15
    } exc_code_e;

endpackage

`default_nettype wire

/* hw/exec_alu.sv */
`default_nettype none

module exec_alu (
    input  exec_pkg::exec_op_e op_i,
    input  exec_pkg::word_t    rs1_data_i,
    input  exec_pkg::word_t    second_operand_i,
    input  exec_pkg::word_t    pc_next_i,
    input  exec_pkg::word_t    jump_imm_target_i,
    output exec_pkg::word_t    sum_o,
    output exec_pkg::word_t    result_o,
    output logic               jump_o,
    output exec_pkg::word_t    jump_target_o
);
    import exec_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    word_t              sum;
    logic               equal;
    logic               less_than;
    logic               less_than_unsigned;

    ////////////////////////////////////////////////////////////////////////////
    // Operators
    ////////////////////////////////////////////////////////////////////////////

    // Shared adder that also feeds the load/store address and JALR target
    assign sum = (op_i == SUB) ? rs1_data_i - second_operand_i
                               : rs1_data_i + second_operand_i;

    assign shamt              = second_operand_i[SHAMT_W-1:0];
    assign equal              = (rs1_data_i == second_operand_i);
    assign less_than          = $signed(rs1_data_i) < $signed(second_operand_i);
    assign less_than_unsigned = rs1_data_i < second_operand_i;

    assign sum_o = sum;

    // Result select
    always_comb begin
        case (op_i)
            ADD, SUB:  result_o = sum;
            AND:       result_o = rs1_data_i & second_operand_i;
            OR:        result_o = rs1_data_i | second_operand_i;
            XOR:       result_o = rs1_data_i ^ second_operand_i;
            SLL:       result_o = rs1_data_i << shamt;
            SRL:       result_o = rs1_data_i >> shamt;
            SRA:       result_o = $signed(rs1_data_i) >>> shamt;
            SLT:       result_o = {{(XLEN-1){1'b0}}, less_than};
            SLTU:      result_o = {{(XLEN-1){1'b0}}, less_than_unsigned};
            LUI:       result_o = second_operand_i;
            AUIPC:     result_o = jump_imm_target_i;
            JAL, JALR: result_o = pc_next_i;
            default:   result_o = sum;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            BEQ:       jump_o = equal;
            BNE:       jump_o = !equal;
            BLT:       jump_o = less_than;
            BLTU:      jump_o = less_than_unsigned;
            BGE:       jump_o = !less_than;
            BGEU:      jump_o = !less_than_unsigned;
            JAL, JALR: jump_o = 1'b1;
            default:   jump_o = 1'b0;
        endcase
    end

    // JALR drops bit 0 of rs1 + imm
    assign jump_target_o = (op_i == JALR) ? {sum[XLEN-1:1], 1'b0} : jump_imm_target_i;

endmodule

`default_nettype wire

/* hw/exec_lsu.sv */
`default_nettype none

module exec_lsu (
    input  exec_pkg::exec_op_e op_i,
    input  exec_pkg::word_t    sum_i,
    input  exec_pkg::word_t    rs2_data_i,
    output exec_pkg::word_t    mem_address_o,
    output logic               mem_read_enable_o,
    output exec_pkg::byte_en_t mem_write_enable_o,
    output exec_pkg::word_t    mem_write_data_o,
    output logic               load_misaligned_o,
    output logic               store_misaligned_o
);
    import exec_pkg::*;

    logic half_access;
    logic word_access;

    assign mem_address_o     = sum_i;
    assign mem_read_enable_o = op_i inside {LB, LBU, LH, LHU, LW};

    // Narrow stores put the data on every lane
    always_comb begin
        case (op_i)
            SB:      mem_write_data_o = {BYTES_PER_WORD{rs2_data_i[7:0]}};
            SH:      mem_write_data_o = {(BYTES_PER_WORD/2){rs2_data_i[15:0]}};
            default: mem_write_data_o = rs2_data_i;
        endcase
    end

    // Byte lanes from the low address bits
    always_comb begin
        mem_write_enable_o = '0;
        case (op_i)
            SB:      mem_write_enable_o[sum_i[1:0]] = 1'b1;
            SH:      mem_write_enable_o = sum_i[1] ? 4'b1100 : 4'b0011;
            SW:      mem_write_enable_o = '1;
            default: mem_write_enable_o = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Alignment checks
    ////////////////////////////////////////////////////////////////////////////

    assign half_access = sum_i[0] && (op_i inside {LH, LHU, SH});
    assign word_access = (sum_i[1:0] != 2'b00) && (op_i inside {LW, SW});

    assign load_misaligned_o  = (half_access || word_access) && mem_read_enable_o;
    assign store_misaligned_o = (half_access || word_access) && (op_i inside {SH, SW});

endmodule

`default_nettype wire

/* hw/exec_trap.sv */
`default_nettype none

module exec_trap (
    input  exec_pkg::exec_op_e  op_i,
    input  logic                illegal_instr_i,
    input  logic                jump_i,
    input  logic                jump_target_bit1_i,
    input  logic                load_misaligned_i,
    input  logic                store_misaligned_i,
    output logic                raise_exception_o,
    output exec_pkg::exc_code_e exception_code_o
);
    import exec_pkg::*;

    logic instr_misaligned;

    // Without compressed support bit 1 of a taken target is a fault
    assign instr_misaligned = jump_i && jump_target_bit1_i;

    assign raise_exception_o = (op_i != NOP) && (
        illegal_instr_i ||
        instr_misaligned ||
        (op_i inside {ECALL, EBREAK}) ||
        load_misaligned_i ||
        store_misaligned_i
    );

    // Highest priority first
    always_comb begin
        if (op_i == NOP)
            exception_code_o = EXC_NONE;
        else if (illegal_instr_i)
            exception_code_o = ILLEGAL_INSTR;
        else if (instr_misaligned)
            exception_code_o = INSTR_ADDR_MISALIGNED;
        else if (op_i == ECALL)
            exception_code_o = ECALL_MMODE;
        else if (op_i == EBREAK)
            exception_code_o = BREAKPOINT;
        else if (load_misaligned_i)
            exception_code_o = LOAD_ADDR_MISALIGNED;
        else if (store_misaligned_i)
            exception_code_o = STORE_ADDR_MISALIGNED;
        else
            exception_code_o = EXC_NONE;
    end

endmodule

`default_nettype wire

/* hw/exec_retire_reg.sv */
`default_nettype none

module exec_retire_reg (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               stall_i,
    input  exec_pkg::exec_op_e op_i,
    input  exec_pkg::reg_addr_t rd_i,
    input  logic               raise_exception_i,
    input  exec_pkg::word_t    result_i,
    input  exec_pkg::word_t    mem_address_i,
    input  logic               mem_read_enable_i,
    input  exec_pkg::byte_en_t mem_write_enable_i,
    input  exec_pkg::word_t    mem_write_data_i,
    output exec_pkg::word_t    result_o,
    output exec_pkg::reg_addr_t rd_o,
    output logic               write_enable_o,
    output exec_pkg::word_t    mem_address_o,
    output logic               mem_read_enable_o,
    output exec_pkg::byte_en_t mem_write_enable_o,
    output exec_pkg::word_t    mem_write_data_o
);
    import exec_pkg::*;

    logic write_enable;

    // Stores and conditional branches have no destination
    always_comb begin
        case (op_i)
            NOP, SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU: write_enable = 1'b0;
            default: write_enable = (rd_i != '0) && !raise_exception_i;
        endcase
    end

    // Memory enables pass through even on a trap
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o           <= '0;
            rd_o               <= '0;
            write_enable_o     <= 1'b0;
            mem_address_o      <= '0;
            mem_read_enable_o  <= 1'b0;
            mem_write_enable_o <= '0;
            mem_write_data_o   <= '0;
        end else if (!stall_i) begin
            result_o           <= result_i;
            rd_o               <= rd_i;
            write_enable_o     <= write_enable;
            mem_address_o      <= mem_address_i;
            mem_read_enable_o  <= mem_read_enable_i;
            mem_write_enable_o <= mem_write_enable_i;
            mem_write_data_o   <= mem_write_data_i;
        end
    end

endmodule

`default_nettype wire

/* hw/execute_top.sv */
`default_nettype none

module execute_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  exec_pkg::exec_op_e  op_i,
    input  exec_pkg::word_t     rs1_data_i,
    input  exec_pkg::word_t     rs2_data_i,
    input  exec_pkg::word_t     second_operand_i,
    input  exec_pkg::reg_addr_t rd_i,
    input  exec_pkg::word_t     pc_next_i,
    input  exec_pkg::word_t     jump_imm_target_i,
    input  logic                illegal_instr_i,
    // Same-cycle outputs
    output exec_pkg::word_t     result_fwd_o,
    output exec_pkg::word_t     mem_address_exec_o,
    output logic                jump_o,
    output exec_pkg::word_t     jump_target_o,
    output logic                raise_exception_o,
    output exec_pkg::exc_code_e exception_code_o,
    // Registered outputs
    output exec_pkg::word_t     result_o,
    output exec_pkg::reg_addr_t rd_o,
    output logic                write_enable_o,
    output exec_pkg::word_t     mem_address_o,
    output logic                mem_read_enable_o,
    output exec_pkg::byte_en_t  mem_write_enable_o,
    output exec_pkg::word_t     mem_write_data_o
);
    import exec_pkg::*;

    word_t    sum;
    logic     mem_read_enable;
    byte_en_t mem_write_enable;
    word_t    mem_write_data;
    logic     load_misaligned;
    logic     store_misaligned;

    exec_alu u_alu (
        .op_i              (op_i),
        .rs1_data_i        (rs1_data_i),
        .second_operand_i  (second_operand_i),
        .pc_next_i         (pc_next_i),
        .jump_imm_target_i (jump_imm_target_i),
        .sum_o             (sum),
        .result_o          (result_fwd_o),
        .jump_o            (jump_o),
        .jump_target_o     (jump_target_o)
    );

    exec_lsu u_lsu (
        .op_i               (op_i),
        .sum_i              (sum),
        .rs2_data_i         (rs2_data_i),
        .mem_address_o      (mem_address_exec_o),
        .mem_read_enable_o  (mem_read_enable),
        .mem_write_enable_o (mem_write_enable),
        .mem_write_data_o   (mem_write_data),
        .load_misaligned_o  (load_misaligned),
        .store_misaligned_o (store_misaligned)
    );

    exec_trap u_trap (
        .op_i               (op_i),
        .illegal_instr_i    (illegal_instr_i),
        .jump_i             (jump_o),
        .jump_target_bit1_i (jump_target_o[1]),
        .load_misaligned_i  (load_misaligned),
        .store_misaligned_i (store_misaligned),
        .raise_exception_o  (raise_exception_o),
        .exception_code_o   (exception_code_o)
    );

    exec_retire_reg u_retire (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall_i            (stall_i),
        .op_i               (op_i),
        .rd_i               (rd_i),
        .raise_exception_i  (raise_exception_o),
        .result_i           (result_fwd_o),
        .mem_address_i      (mem_address_exec_o),
        .mem_read_enable_i  (mem_read_enable),
        .mem_write_enable_i (mem_write_enable),
        .mem_write_data_i   (mem_write_data),
        .result_o           (result_o),
        .rd_o               (rd_o),
        .write_enable_o     (write_enable_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    // 20-unit period starting low
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* sim/execute_asserts.sv */
`default_nettype none

module execute_asserts (
    input logic                clk,
    input logic                reset_n,
    input logic                stall_i,
    input exec_pkg::reg_addr_t rd_i,
    input logic                write_enable_i,
    input logic                raise_exception_i,
    input exec_pkg::exc_code_e exception_code_i,
    input exec_pkg::word_t     result_i,
    input exec_pkg::word_t     mem_address_i,
    input logic                mem_read_enable_i,
    input exec_pkg::byte_en_t  mem_write_enable_i,
    input exec_pkg::word_t     mem_write_data_i
);
    import exec_pkg::*;

    // Byte lanes a byte, halfword or word store can produce
    legal_byte_enable: assert property (@(posedge clk) disable iff (!reset_n)
        mem_write_enable_i inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                   4'b0011, 4'b1100, 4'b1111})
        else $error("illegal byte enable mask %b", mem_write_enable_i);

    write_needs_rd: assert property (@(posedge clk) disable iff (!reset_n)
        write_enable_i |-> (rd_i != '0))
        else $error("register write enabled for x0");

    exception_has_code: assert property (@(posedge clk) disable iff (!reset_n)
        raise_exception_i |-> (exception_code_i != EXC_NONE))
        else $error("exception raised without a cause code");

    // Nothing in the retire register may move while stalled
    hold_under_stall: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> $stable({result_i, rd_i, write_enable_i, mem_address_i,
                             mem_read_enable_i, mem_write_enable_i, mem_write_data_i}))
        else $error("registered outputs changed while stalled");

endmodule

bind execute_top execute_asserts u_asserts (
    .clk                (clk),
    .reset_n            (reset_n),
    .stall_i            (stall_i),
    .rd_i               (rd_o),
    .write_enable_i     (write_enable_o),
    .raise_exception_i  (raise_exception_o),
    .exception_code_i   (exception_code_o),
    .result_i           (result_o),
    .mem_address_i      (mem_address_o),
    .mem_read_enable_i  (mem_read_enable_o),
    .mem_write_enable_i (mem_write_enable_o),
    .mem_write_data_i   (mem_write_data_o)
);

`default_nettype wire

/* sim/execute_tb.sv */
`default_nettype none

module execute_tb;
    import exec_pkg::*;

    localparam int    RESET_CYCLES  = 10;
    localparam int    RESET_TIMEOUT = 40;
    localparam int    STALL_CYCLES  = 4;
    localparam int    RANDOM_VECS   = 16;
    localparam word_t PC_NEXT       = 32'h0000_1004;
    localparam word_t IMM_TGT       = 32'h0000_2000;

    typedef struct packed {
        exec_op_e  op;
        word_t     rs1;
        word_t     rs2;
        word_t     opnd;
        reg_addr_t rd;
        logic      illegal;
        word_t     result;
        logic      jump;
        word_t     target;
        exc_code_e code;
        byte_en_t  be;
        word_t     wdata;
    } vec_t;

    logic      clk;
    logic      reset_n;
    logic      stall;
    exec_op_e  op;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     second_operand;
    reg_addr_t rd;
    word_t     pc_next;
    word_t     jump_imm_target;
    logic      illegal_instr;
    word_t     result_fwd;
    word_t     mem_address_exec;
    logic      jump;
    word_t     jump_target;
    logic      raise_exception;
    exc_code_e exception_code;
    word_t     result;
    reg_addr_t rd_out;
    logic      write_enable;
    word_t     mem_address;
    logic      mem_read_enable;
    byte_en_t  mem_write_enable;
    word_t     mem_write_data;

    vec_t   vecs[$];
    string  names[$];
    vec_t   idle_vec;
    integer seed;

    // Branch operand pairs are equal, less, greater, and minus one against one
    exec_op_e   br_ops[$]   = '{BEQ, BNE, BLT, BLTU, BGE, BGEU};
    logic [3:0] br_taken[$] = '{4'b1000, 4'b0111, 4'b0101, 4'b0100, 4'b1010, 4'b1011};
    word_t      br_a[$]     = '{32'd5, 32'd2, 32'd7, 32'hffff_ffff};
    word_t      br_b[$]     = '{32'd5, 32'd7, 32'd2, 32'd1};
    exec_op_e   rand_ops[$] = '{ADD, SUB, XOR, SLT};

    tb_clock_gen u_clock (.clk_o(clk));

    execute_top dut0 (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall_i            (stall),
        .op_i               (op),
        .rs1_data_i         (rs1_data),
        .rs2_data_i         (rs2_data),
        .second_operand_i   (second_operand),
        .rd_i               (rd),
        .pc_next_i          (pc_next),
        .jump_imm_target_i  (jump_imm_target),
        .illegal_instr_i    (illegal_instr),
        .result_fwd_o       (result_fwd),
        .mem_address_exec_o (mem_address_exec),
        .jump_o             (jump),
        .jump_target_o      (jump_target),
        .raise_exception_o  (raise_exception),
        .exception_code_o   (exception_code),
        .result_o           (result),
        .rd_o               (rd_out),
        .write_enable_o     (write_enable),
        .mem_address_o      (mem_address),
        .mem_read_enable_o  (mem_read_enable),
        .mem_write_enable_o (mem_write_enable),
        .mem_write_data_o   (mem_write_data)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_vec(input string name, input vec_t v);
        names.push_back(name);
        vecs.push_back(v);
    endtask

    function automatic logic is_load(input vec_t v);
        return v.op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic logic is_mem(input vec_t v);
        return is_load(v) || (v.op inside {SB, SH, SW});
    endfunction

    // Destination written unless no rd, no destination, or trapped
    function automatic logic expect_write(input vec_t v);
        if (v.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU})
            return 1'b0;
        return (v.rd != 5'd0) && (v.code == EXC_NONE);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        word_t      a;
        word_t      b;
        word_t      expected;
        logic [1:0] pick;
        reg_addr_t  rd_rand;
        add_vec("add",      vec_t'{ADD, 32'd5, 32'd0, 32'd7, 5'd1, 1'b0,
                            32'd12, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("sub",      vec_t'{SUB, 32'd3, 32'd0, 32'd5, 5'd2, 1'b0,
                            32'hffff_fffe, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("and",      vec_t'{AND, 32'hf0f0_f0f0, 32'd0, 32'h0ff0_0ff0, 5'd3, 1'b0,
                            32'h00f0_00f0, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("xor x0",   vec_t'{XOR, 32'hf0f0_f0f0, 32'd0, 32'h0ff0_0ff0, 5'd0, 1'b0,
                            32'hff00_ff00, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("sll",      vec_t'{SLL, 32'd1, 32'd0, 32'h24, 5'd5, 1'b0,
                            32'h10, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("srl",      vec_t'{SRL, 32'h8000_0000, 32'd0, 32'd4, 5'd6, 1'b0,
                            32'h0800_0000, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("sra",      vec_t'{SRA, 32'h8000_0000, 32'd0, 32'd4, 5'd7, 1'b0,
                            32'hf800_0000, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("slt",      vec_t'{SLT, 32'hffff_ffff, 32'd0, 32'd1, 5'd8, 1'b0,
                            32'd1, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("sltu",     vec_t'{SLTU, 32'hffff_ffff, 32'd0, 32'd1, 5'd9, 1'b0,
                            32'd0, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("lui",      vec_t'{LUI, 32'd0, 32'd0, 32'h1234_5000, 5'd10, 1'b0,
                            32'h1234_5000, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("auipc",    vec_t'{AUIPC, 32'd0, 32'd0, 32'h400, 5'd11, 1'b0,
                            IMM_TGT, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("jal",      vec_t'{JAL, 32'h100, 32'd0, 32'd8, 5'd1, 1'b0,
                            PC_NEXT, 1'b1, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        add_vec("jalr",     vec_t'{JALR, 32'h301, 32'd0, 32'd4, 5'd1, 1'b0,
                            PC_NEXT, 1'b1, 32'h304, EXC_NONE, 4'b0000, 32'd0});
        add_vec("sb",       vec_t'{SB, 32'h100, 32'h1234_56a5, 32'd3, 5'd0, 1'b0,
                            32'h103, 1'b0, IMM_TGT, EXC_NONE, 4'b1000, 32'ha5a5_a5a5});
        add_vec("sh",       vec_t'{SH, 32'h100, 32'h0000_beef, 32'd2, 5'd0, 1'b0,
                            32'h102, 1'b0, IMM_TGT, EXC_NONE, 4'b1100, 32'hbeef_beef});
        add_vec("sw",       vec_t'{SW, 32'h100, 32'hcafe_f00d, 32'd4, 5'd0, 1'b0,
                            32'h104, 1'b0, IMM_TGT, EXC_NONE, 4'b1111, 32'hcafe_f00d});
        add_vec("lw",       vec_t'{LW, 32'h200, 32'd0, 32'd4, 5'd6, 1'b0,
                            32'h204, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        // Exceptions and the priority where two causes meet
        add_vec("lh mis",   vec_t'{LH, 32'h200, 32'd0, 32'd1, 5'd8, 1'b0,
                            32'h201, 1'b0, IMM_TGT, LOAD_ADDR_MISALIGNED, 4'b0000, 32'd0});
        add_vec("sw mis",   vec_t'{SW, 32'h100, 32'h1111_2222, 32'd6, 5'd0, 1'b0,
                            32'h106, 1'b0, IMM_TGT, STORE_ADDR_MISALIGNED, 4'b1111,
                            32'h1111_2222});
        add_vec("jalr mis", vec_t'{JALR, 32'h300, 32'd0, 32'd2, 5'd1, 1'b0,
                            PC_NEXT, 1'b1, 32'h302, INSTR_ADDR_MISALIGNED, 4'b0000, 32'd0});
        add_vec("ecall",    vec_t'{ECALL, 32'd0, 32'd0, 32'd0, 5'd4, 1'b0,
                            32'd0, 1'b0, IMM_TGT, ECALL_MMODE, 4'b0000, 32'd0});
        add_vec("ebreak",   vec_t'{EBREAK, 32'd0, 32'd0, 32'd0, 5'd4, 1'b0,
                            32'd0, 1'b0, IMM_TGT, BREAKPOINT, 4'b0000, 32'd0});
        add_vec("illegal",  vec_t'{ADD, 32'd5, 32'd0, 32'd7, 5'd9, 1'b1,
                            32'd12, 1'b0, IMM_TGT, ILLEGAL_INSTR, 4'b0000, 32'd0});
        add_vec("ill jalr", vec_t'{JALR, 32'h300, 32'd0, 32'd2, 5'd1, 1'b1,
                            PC_NEXT, 1'b1, 32'h302, ILLEGAL_INSTR, 4'b0000, 32'd0});
        add_vec("nop ill",  vec_t'{NOP, 32'd0, 32'd0, 32'd0, 5'd1, 1'b1,
                            32'd0, 1'b0, IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        for (int bi = 0; bi < 6; bi++) begin
            for (int p = 0; p < 4; p++) begin
                add_vec($sformatf("%s pair %0d", br_ops[bi].name(), p),
                        vec_t'{br_ops[bi], br_a[p], 32'd0, br_b[p], 5'd3, 1'b0,
                               br_a[p] + br_b[p], br_taken[bi][2'(3 - p)], IMM_TGT,
                               EXC_NONE, 4'b0000, 32'd0});
            end
        end
        for (int n = 0; n < RANDOM_VECS; n++) begin
            pick = 2'($random(seed));
            a = $random(seed);
            b = $random(seed);
            rd_rand = 5'($random(seed));
            case (rand_ops[pick])
                ADD:     expected = a + b;
                SUB:     expected = a - b;
                XOR:     expected = a ^ b;
                default: expected = {31'd0, $signed(a) < $signed(b)};
            endcase
            add_vec($sformatf("random %0d", n),
                    vec_t'{rand_ops[pick], a, 32'd0, b, rd_rand, 1'b0, expected, 1'b0,
                           IMM_TGT, EXC_NONE, 4'b0000, 32'd0});
        end
    endtask

    task automatic drive_vec(input vec_t v);
        op             <= v.op;
        rs1_data       <= v.rs1;
        rs2_data       <= v.rs2;
        second_operand <= v.opnd;
        rd             <= v.rd;
        illegal_instr  <= v.illegal;
    endtask

    task automatic check_comb(input int i);
        vec_t v;
        v = vecs[i];
        check_value({names[i], " result_fwd"}, v.result, result_fwd);
        check_value({names[i], " jump"}, 32'(v.jump), 32'(jump));
        check_value({names[i], " jump_target"}, v.target, jump_target);
        check_value({names[i], " raise"}, 32'(v.code != EXC_NONE), 32'(raise_exception));
        check_value({names[i], " code"}, 32'(v.code), 32'(exception_code));
        if (is_mem(v))
            check_value({names[i], " address"}, v.result, mem_address_exec);
    endtask

    task automatic check_retired(input int i);
        vec_t v;
        v = vecs[i];
        check_value({names[i], " result"}, v.result, result);
        check_value({names[i], " rd"}, 32'(v.rd), 32'(rd_out));
        check_value({names[i], " write_enable"}, 32'(expect_write(v)), 32'(write_enable));
        check_value({names[i], " read_enable"}, 32'(is_load(v)), 32'(mem_read_enable));
        check_value({names[i], " byte_enable"}, 32'(v.be), 32'(mem_write_enable));
        check_value({names[i], " write_data"}, v.wdata, mem_write_data);
        if (is_mem(v))
            check_value({names[i], " mem_address"}, v.result, mem_address);
    endtask

    task automatic check_reset_values();
        check_value("reset result", 32'd0, result);
        check_value("reset rd", 32'd0, 32'(rd_out));
        check_value("reset write_enable", 32'd0, 32'(write_enable));
        check_value("reset mem_address", 32'd0, mem_address);
        check_value("reset read_enable", 32'd0, 32'(mem_read_enable));
        check_value("reset byte_enable", 32'd0, 32'(mem_write_enable));
        check_value("reset write_data", 32'd0, mem_write_data);
    endtask

    initial begin : reset_seq
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

    initial begin : main_seq
        int waited;
        // A load into x5 waits on the inputs through reset
        stall           = 1'b0;
        op              = LW;
        rs1_data        = 32'h0000_0300;
        rs2_data        = 32'h5a5a_5a5a;
        second_operand  = 32'd8;
        rd              = 5'd5;
        pc_next         = PC_NEXT;
        jump_imm_target = IMM_TGT;
        illegal_instr   = 1'b0;
        idle_vec        = '0;
        seed            = 32'h7607;
        build_table();

        waited = 0;
        while (reset_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                $display("Reset was still asserted after %0d cycles", waited);
                $display("TESTBENCH FAILED");
                $fatal(1, "reset release timeout");
            end
        end
        check_reset_values();

        // One entry per cycle; the register shows the previous entry
        for (int i = 0; i <= vecs.size(); i++) begin
            @(posedge clk);
            if (i < vecs.size())
                drive_vec(vecs[i]);
            else
                drive_vec(idle_vec);
            @(negedge clk);
            if (i > 0)
                check_retired(i - 1);
            if (i < vecs.size())
                check_comb(i);
        end

        ////////////////////////////////////////////////////////////////////////
        // Stall holds the add while other entries are presented
        ////////////////////////////////////////////////////////////////////////
        @(posedge clk);
        drive_vec(vecs[0]);
        @(posedge clk);
        stall <= 1'b1;
        drive_vec(vecs[2]);
        for (int n = 0; n < STALL_CYCLES; n++) begin
            @(negedge clk);
            check_retired(0);
            @(posedge clk);
            if (n < STALL_CYCLES - 1) begin
                drive_vec(vecs[3 + n]);
            end else begin
                stall <= 1'b0;
                drive_vec(vecs[1]);
            end
        end
        @(negedge clk);
        check_retired(0);
        @(posedge clk);
        drive_vec(idle_vec);
        @(negedge clk);
        check_retired(1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* execute_top.f */
hw/exec_pkg.sv
hw/exec_alu.sv
hw/exec_lsu.sv
hw/exec_trap.sv
hw/exec_retire_reg.sv
hw/execute_top.sv
sim/tb_clock_gen.sv
sim/execute_asserts.sv
sim/execute_tb.sv

/* Makefile */
# Verilator flow for the execute stage

TB_TOP = execute_tb

lint:
	verilator --lint-only --timing --assert --top-module $(TB_TOP) -f execute_top.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f execute_top.f
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir

.PHONY: lint sim clean
